/* csr_cfg.svh */
`ifndef CSR_CFG_SVH
`define CSR_CFG_SVH

// data path and pc width
`define XLEN 64

// machine trap setup
`define CSR_MSTATUS  12'h300
`define CSR_MTVEC    12'h305

// machine trap handling
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342

// machine counter, writable from M mode
`define CSR_MCYCLE   12'hb00

`endif

/* csr_pkg.sv */
`default_nettype none

package csr_pkg;

	// what the decode stage made of one instruction
	typedef enum logic [2:0] {
		KIND_CSR     = 3'd0, // any of the six csr forms
		KIND_ECALL   = 3'd1,
		KIND_EBREAK  = 3'd2,
		KIND_MRET    = 3'd3,
		KIND_ILLEGAL = 3'd4
	} instr_kind_t;

	// encoded like funct3[1:0] so decode can cast straight across
	typedef enum logic [1:0] {
		OP_RW = 2'b01,
		OP_RS = 2'b10,
		OP_RC = 2'b11
	} csr_op_t;

	// exception code field of mcause, interrupt flag lives in bit 63
	typedef logic [3:0] trap_cause_t;

	localparam trap_cause_t CAUSE_ILLEGAL    = 4'd2;
	localparam trap_cause_t CAUSE_BREAKPOINT = 4'd3;
	localparam trap_cause_t CAUSE_ECALL_M    = 4'd11;
	localparam trap_cause_t CAUSE_MEXT_IRQ   = 4'd11; // with interrupt flag set

endpackage

`default_nettype wire

/* csr_decode.sv */
`default_nettype none
`include "csr_cfg.svh"

module csr_decode (
	input  wire                  clk,
	input  wire                  reset,
	input  wire                  instr_valid,
	input  wire [31:0]           instr,
	input  wire [`XLEN-1:0]      pc,
	input  wire [`XLEN-1:0]      rs1_data,
	input  wire                  ext_irq,
	output logic                 dec_valid,
	output csr_pkg::instr_kind_t dec_kind,
	output csr_pkg::csr_op_t     dec_op,
	output logic [11:0]          dec_addr,
	output logic [`XLEN-1:0]     dec_wdata,
	output logic                 dec_wen,
	output logic [4:0]           dec_rd,
	output logic [`XLEN-1:0]     dec_pc,
	output logic                 dec_irq
);
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	logic [6:0]           opcode;
	logic [4:0]           rd_f;
	logic [2:0]           funct3;
	logic [4:0]           rs1_f; // register index, or uimm for the i forms
	logic [11:0]          funct12; // csr address for csr forms
	csr_pkg::instr_kind_t kind_c;
	csr_pkg::csr_op_t     op_c;
	logic [`XLEN-1:0]     wdata_c;
	logic                 wen_c;

	assign opcode  = instr[6:0];
	assign rd_f    = instr[11:7];
	assign funct3  = instr[14:12];
	assign rs1_f   = instr[19:15];
	assign funct12 = instr[31:20];

	always_comb begin
		kind_c = csr_pkg::KIND_ILLEGAL;
		op_c   = csr_pkg::OP_RW;
		if (opcode == OPC_SYSTEM) begin
			if (funct3 == 3'b000) begin
				// priv group, needs rs1 and rd both zero
				if (rs1_f == 5'd0 && rd_f == 5'd0) begin
					case (funct12)
						12'h000: kind_c = csr_pkg::KIND_ECALL;
						12'h001: kind_c = csr_pkg::KIND_EBREAK;
						12'h302: kind_c = csr_pkg::KIND_MRET;
						default: kind_c = csr_pkg::KIND_ILLEGAL; // wfi, sret etc
					endcase
				end
			end else if (funct3 != 3'b100) begin
				kind_c = csr_pkg::KIND_CSR;
				op_c   = csr_pkg::csr_op_t'(funct3[1:0]);
			end
		end
	end

	// immediate forms use the zero extended rs1 field
	assign wdata_c = funct3[2] ? {{(`XLEN-5){1'b0}}, rs1_f} : rs1_data;

	// set/clear with x0 or uimm 0 only reads
	assign wen_c = (kind_c == csr_pkg::KIND_CSR) &&
		(op_c == csr_pkg::OP_RW || rs1_f != 5'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			dec_kind  <= kind_c;
			dec_op    <= op_c;
			dec_addr  <= funct12;
			dec_wdata <= wdata_c;
			dec_wen   <= wen_c;
			dec_rd    <= rd_f;
			dec_pc    <= pc;
			dec_irq   <= ext_irq; // irq level seen with this instr
		end
	end

endmodule

`default_nettype wire

/* csr_file.sv */
`default_nettype none
`include "csr_cfg.svh"

module csr_file (
	input  wire                       clk,
	input  wire                       reset,
	input  wire                       dec_valid,
	input  wire csr_pkg::instr_kind_t dec_kind,
	input  wire csr_pkg::csr_op_t     dec_op,
	input  wire [11:0]                dec_addr,
	input  wire [`XLEN-1:0]           dec_wdata,
	input  wire                       dec_wen,
	input  wire [4:0]                 dec_rd,
	input  wire [`XLEN-1:0]           dec_pc,
	input  wire                       dec_irq,
	output logic                      ex_valid,
	output logic                      ex_rd_we,
	output logic [4:0]                ex_rd,
	output logic [`XLEN-1:0]          ex_rdata,
	output logic                      ex_redirect,
	output logic [`XLEN-1:0]          ex_target
);
	logic                 mie;
	logic                 mpie;
	logic [`XLEN-1:0]     mstatus; // assembled view, mpp fixed to M
	logic [`XLEN-1:0]     mtvec;
	logic [`XLEN-1:0]     mepc;
	logic [`XLEN-1:0]     mcause;
	logic [`XLEN-1:0]     mscratch;
	logic [`XLEN-1:0]     mcycle;
	logic                 addr_ok;
	logic [`XLEN-1:0]     old_val;
	logic [`XLEN-1:0]     new_val;
	logic                 is_csr;
	logic                 take_irq;
	logic                 take_exc;
	logic                 trap;
	logic                 do_mret;
	logic                 csr_wr;
	csr_pkg::trap_cause_t cause;
	logic [`XLEN-1:0]     tvec_base;

	assign mstatus = {{(`XLEN-13){1'b0}}, 2'b11, 3'b000, mpie, 3'b000, mie, 3'b000};

	// read mux, also flags unknown addresses
	always_comb begin
		addr_ok = 1'b1;
		case (dec_addr)
			`CSR_MSTATUS:  old_val = mstatus;
			`CSR_MTVEC:    old_val = mtvec;
			`CSR_MEPC:     old_val = mepc;
			`CSR_MCAUSE:   old_val = mcause;
			`CSR_MSCRATCH: old_val = mscratch;
			`CSR_MCYCLE:   old_val = mcycle; // value before this edge's increment
			default: begin
				old_val = '0;
				addr_ok = 1'b0;
			end
		endcase
	end

	always_comb begin
		case (dec_op)
			csr_pkg::OP_RS: new_val = old_val | dec_wdata;
			csr_pkg::OP_RC: new_val = old_val & ~dec_wdata;
			default:        new_val = dec_wdata;
		endcase
	end

	// irq beats the instruction's own exception, which beats the write
	assign is_csr   = dec_valid && dec_kind == csr_pkg::KIND_CSR;
	assign take_irq = dec_valid && dec_irq && mie;
	assign take_exc = dec_valid && !take_irq && dec_kind != csr_pkg::KIND_MRET &&
		!(dec_kind == csr_pkg::KIND_CSR && addr_ok);
	assign trap     = take_irq || take_exc;
	assign do_mret  = dec_valid && !take_irq && dec_kind == csr_pkg::KIND_MRET;
	assign csr_wr   = is_csr && !trap && dec_wen;

	always_comb begin
		if (take_irq) begin
			cause = csr_pkg::CAUSE_MEXT_IRQ;
		end else begin
			case (dec_kind)
				csr_pkg::KIND_ECALL:  cause = csr_pkg::CAUSE_ECALL_M;
				csr_pkg::KIND_EBREAK: cause = csr_pkg::CAUSE_BREAKPOINT;
				default:              cause = csr_pkg::CAUSE_ILLEGAL; // incl bad csr addr
			endcase
		end
	end

	assign tvec_base = {mtvec[`XLEN-1:2], 2'b00};

	always_comb begin
		if (do_mret) begin
			ex_target = mepc;
		end else if (take_irq && mtvec[1:0] == 2'b01) begin
			ex_target = tvec_base + {{(`XLEN-6){1'b0}}, cause, 2'b00}; // vectored
		end else begin
			ex_target = tvec_base;
		end
	end

	assign ex_valid    = dec_valid;
	assign ex_rd_we    = is_csr && !trap && dec_rd != 5'd0;
	assign ex_rd       = dec_rd;
	assign ex_rdata    = old_val;
	assign ex_redirect = trap || do_mret;

	always_ff @(posedge clk) begin
		if (reset) begin
			mie  <= 1'b0;
			mpie <= 1'b0;
		end else if (trap) begin
			mpie <= mie;
			mie  <= 1'b0;
		end else if (do_mret) begin
			mie  <= mpie;
			mpie <= 1'b1;
		end else if (csr_wr && dec_addr == `CSR_MSTATUS) begin
			mie  <= new_val[3]; // everything else in mstatus is read-only here
			mpie <= new_val[7];
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mtvec <= '0;
		end else if (csr_wr && dec_addr == `CSR_MTVEC) begin
			mtvec <= {new_val[`XLEN-1:2], new_val[1] ? 2'b00 : new_val[1:0]}; // modes 2,3 -> direct
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mepc <= '0;
		end else if (trap) begin
			mepc <= {dec_pc[`XLEN-1:2], 2'b00};
		end else if (csr_wr && dec_addr == `CSR_MEPC) begin
			mepc <= {new_val[`XLEN-1:2], 2'b00};
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mcause <= '0;
		end else if (trap) begin
			mcause <= {take_irq, {(`XLEN-5){1'b0}}, cause};
		end else if (csr_wr && dec_addr == `CSR_MCAUSE) begin
			mcause <= new_val;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mscratch <= '0;
		end else if (csr_wr && dec_addr == `CSR_MSCRATCH) begin
			mscratch <= new_val;
		end
	end

	// free running, a write replaces the increment for that cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			mcycle <= '0;
		end else if (csr_wr && dec_addr == `CSR_MCYCLE) begin
			mcycle <= new_val;
		end else begin
			mcycle <= mcycle + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* csr_writeback.sv */
`default_nettype none
`include "csr_cfg.svh"

module csr_writeback (
	input  wire               clk,
	input  wire               reset,
	input  wire               ex_valid,
	input  wire               ex_rd_we,
	input  wire [4:0]         ex_rd,
	input  wire [`XLEN-1:0]   ex_rdata,
	input  wire               ex_redirect,
	input  wire [`XLEN-1:0]   ex_target,
	output logic              rd_valid,
	output logic [4:0]        rd_addr,
	output logic [`XLEN-1:0]  rd_data,
	output logic              redirect_valid,
	output logic [`XLEN-1:0]  redirect_pc
);
	logic rd_load;
	logic redir_load;

	assign rd_load    = ex_valid && ex_rd_we;
	assign redir_load = ex_valid && ex_redirect; // never together with rd_load

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_valid       <= 1'b0;
			redirect_valid <= 1'b0;
		end else begin
			rd_valid       <= rd_load;
			redirect_valid <= redir_load;
		end
	end

	// data fields only move with a new result
	always_ff @(posedge clk) begin
		if (rd_load) begin
			rd_addr <= ex_rd;
			rd_data <= ex_rdata;
		end
	end

	always_ff @(posedge clk) begin
		if (redir_load) begin
			redirect_pc <= ex_target;
		end
	end

endmodule

`default_nettype wire

/* csr_unit.sv */
`default_nettype none
`include "csr_cfg.svh"

module csr_unit (
	input  wire               clk,
	input  wire               reset,
	input  wire               instr_valid,
	input  wire [31:0]        instr,
	input  wire [`XLEN-1:0]   pc,
	input  wire [`XLEN-1:0]   rs1_data,
	input  wire               ext_irq,
	output wire               rd_valid,
	output wire [4:0]         rd_addr,
	output wire [`XLEN-1:0]   rd_data,
	output wire               redirect_valid,
	output wire [`XLEN-1:0]   redirect_pc
);
	// decode -> csr file, registered
	wire                       dec_valid;
	wire csr_pkg::instr_kind_t dec_kind;
	wire csr_pkg::csr_op_t     dec_op;
	wire [11:0]                dec_addr;
	wire [`XLEN-1:0]           dec_wdata;
	wire                       dec_wen;
	wire [4:0]                 dec_rd;
	wire [`XLEN-1:0]           dec_pc;
	wire                       dec_irq;

	// csr file -> writeback, same cycle
	wire                       ex_valid;
	wire                       ex_rd_we;
	wire [4:0]                 ex_rd;
	wire [`XLEN-1:0]           ex_rdata;
	wire                       ex_redirect;
	wire [`XLEN-1:0]           ex_target;

	csr_decode u_decode (
		.clk         (clk),
		.reset       (reset),
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.rs1_data    (rs1_data),
		.ext_irq     (ext_irq),
		.dec_valid   (dec_valid),
		.dec_kind    (dec_kind),
		.dec_op      (dec_op),
		.dec_addr    (dec_addr),
		.dec_wdata   (dec_wdata),
		.dec_wen     (dec_wen),
		.dec_rd      (dec_rd),
		.dec_pc      (dec_pc),
		.dec_irq     (dec_irq)
	);

	csr_file u_file (
		.clk         (clk),
		.reset       (reset),
		.dec_valid   (dec_valid),
		.dec_kind    (dec_kind),
		.dec_op      (dec_op),
		.dec_addr    (dec_addr),
		.dec_wdata   (dec_wdata),
		.dec_wen     (dec_wen),
		.dec_rd      (dec_rd),
		.dec_pc      (dec_pc),
		.dec_irq     (dec_irq),
		.ex_valid    (ex_valid),
		.ex_rd_we    (ex_rd_we),
		.ex_rd       (ex_rd),
		.ex_rdata    (ex_rdata),
		.ex_redirect (ex_redirect),
		.ex_target   (ex_target)
	);

	csr_writeback u_writeback (
		.clk            (clk),
		.reset          (reset),
		.ex_valid       (ex_valid),
		.ex_rd_we       (ex_rd_we),
		.ex_rd          (ex_rd),
		.ex_rdata       (ex_rdata),
		.ex_redirect    (ex_redirect),
		.ex_target      (ex_target),
		.rd_valid       (rd_valid),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

endmodule

`default_nettype wire

/* csr_clock_gen.sv */
`default_nettype none

module csr_clock_gen (
	output logic clk,
	output logic reset
);
	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk; // period 40
	end

	initial begin
		reset = 1'b1;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0; // released away from the active edge
	end

endmodule

`default_nettype wire

/* csr_unit_assert.sv */
`default_nettype none
`include "csr_cfg.svh"

module csr_unit_assert (
	input wire              clk,
	input wire              reset,
	input wire              rd_valid,
	input wire              redirect_valid,
	input wire [`XLEN-1:0]  redirect_pc
);
	// outputs come out of reset idle
	property idle_after_reset;
		@(posedge clk) $past(reset) |-> !rd_valid && !redirect_valid;
	endproperty

	// a result is either a writeback or a redirect
	property one_result_kind;
		@(posedge clk) disable iff (reset) !(rd_valid && redirect_valid);
	endproperty

	property redirect_aligned;
		@(posedge clk) disable iff (reset) redirect_valid |-> redirect_pc[1:0] == 2'b00;
	endproperty

	idle_after_reset_a: assert property (idle_after_reset)
		else $error("valid output in the cycle after reset");
	one_result_kind_a: assert property (one_result_kind)
		else $error("rd_valid and redirect_valid set together");
	redirect_aligned_a: assert property (redirect_aligned)
		else $error("redirect_pc not aligned");

endmodule

bind csr_unit csr_unit_assert assert_i (
	.clk            (clk),
	.reset          (reset),
	.rd_valid       (rd_valid),
	.redirect_valid (redirect_valid),
	.redirect_pc    (redirect_pc)
);

`default_nettype wire

/* csr_unit_tb.sv */
`default_nettype none
`include "csr_cfg.svh"

module csr_unit_tb;
	localparam int RAND_N   = 120;
	localparam int WATCHDOG = (RAND_N + 110) * 40 + 4000; // random part plus directed tests

	logic              clk;
	logic              reset;
	logic              instr_valid;
	logic [31:0]       instr;
	logic [`XLEN-1:0]  pc;
	logic [`XLEN-1:0]  rs1_data;
	logic              ext_irq;
	wire               rd_valid;
	wire [4:0]         rd_addr;
	wire [`XLEN-1:0]   rd_data;
	wire               redirect_valid;
	wire [`XLEN-1:0]   redirect_pc;

	// reference CSR state
	logic              m_mie;
	logic              m_mpie;
	logic [`XLEN-1:0]  m_mtvec;
	logic [`XLEN-1:0]  m_mepc;
	logic [`XLEN-1:0]  m_mcause;
	logic [`XLEN-1:0]  m_mscratch;
	logic [`XLEN-1:0]  mc_base; // mcycle value at cycle mc_t
	int                mc_t;

	// expected results in issue order
	int                   due_q[$];
	logic                 rdv_q[$];
	logic [4:0]           rda_q[$];
	logic [`XLEN-1:0]     rdd_q[$];
	logic                 rev_q[$];
	logic [`XLEN-1:0]     rep_q[$];
	csr_pkg::instr_kind_t kind_q[$];
	csr_pkg::trap_cause_t cause_q[$];

	int                cyc;
	int                errors;
	int                checks;
	int                tests;
	int                issued;
	int                test_err0;
	logic [31:0]       lcg_state;
	logic [`XLEN-1:0]  next_pc;

	csr_clock_gen clk_gen_i (.clk(clk), .reset(reset));

	csr_unit dut_i (
		.clk            (clk),
		.reset          (reset),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.pc             (pc),
		.rs1_data       (rs1_data),
		.ext_irq        (ext_irq),
		.rd_valid       (rd_valid),
		.rd_addr        (rd_addr),
		.rd_data        (rd_data),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	// cycles since reset so mcycle can be predicted
	always @(posedge clk) begin
		if (reset) begin
			cyc <= 0;
		end else begin
			cyc <= cyc + 1;
		end
	end

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic logic [31:0] csr_ins(input logic [2:0] f3, input logic [4:0] rd,
		input logic [4:0] src, input logic [11:0] addr);
		return {addr, src, f3, rd, 7'b1110011};
	endfunction

	// runs one instruction on the reference state in execute cycle t
	function automatic void ref_exec(input logic [31:0] ins, input logic [`XLEN-1:0] pc_v,
		input logic [`XLEN-1:0] src_v, input logic irq, input int t,
		output logic rdv, output logic [4:0] rda, output logic [`XLEN-1:0] rdd,
		output logic rev, output logic [`XLEN-1:0] rep,
		output csr_pkg::instr_kind_t kind, output csr_pkg::trap_cause_t cause);
		logic [2:0]       f3;
		logic [4:0]       src;
		logic [11:0]      addr;
		logic             known;
		logic             intr;
		logic             trap;
		logic [`XLEN-1:0] old;
		logic [`XLEN-1:0] opnd;
		logic [`XLEN-1:0] nv;
		f3 = ins[14:12];
		src = ins[19:15];
		addr = ins[31:20];
		kind = csr_pkg::KIND_ILLEGAL;
		if (ins[6:0] == 7'b1110011 && f3 != 3'b000 && f3 != 3'b100) begin
			kind = csr_pkg::KIND_CSR;
		end else if (ins[6:0] == 7'b1110011 && f3 == 3'b000 && src == 0 && ins[11:7] == 0) begin
			if (addr == 12'h000) kind = csr_pkg::KIND_ECALL;
			if (addr == 12'h001) kind = csr_pkg::KIND_EBREAK;
			if (addr == 12'h302) kind = csr_pkg::KIND_MRET;
		end
		known = 1'b1;
		case (addr)
			`CSR_MSTATUS:  old = 64'h1800 | ({63'd0, m_mpie} << 7) | ({63'd0, m_mie} << 3);
			`CSR_MTVEC:    old = m_mtvec;
			`CSR_MEPC:     old = m_mepc;
			`CSR_MCAUSE:   old = m_mcause;
			`CSR_MSCRATCH: old = m_mscratch;
			`CSR_MCYCLE:   old = mc_base + 64'(t - mc_t);
			default: begin
				old = '0;
				known = 1'b0;
			end
		endcase
		rdv = 1'b0;
		rda = ins[11:7];
		rdd = old;
		rev = 1'b0;
		rep = '0;
		intr = irq && m_mie;
		trap = 1'b1;
		cause = csr_pkg::CAUSE_ILLEGAL;
		if (intr) begin
			cause = csr_pkg::CAUSE_MEXT_IRQ;
		end else if (kind == csr_pkg::KIND_ECALL) begin
			cause = csr_pkg::CAUSE_ECALL_M;
		end else if (kind == csr_pkg::KIND_EBREAK) begin
			cause = csr_pkg::CAUSE_BREAKPOINT;
		end else if (kind == csr_pkg::KIND_MRET) begin
			trap = 1'b0;
			rev = 1'b1;
			rep = m_mepc;
			m_mie = m_mpie;
			m_mpie = 1'b1;
		end else if (kind == csr_pkg::KIND_CSR && known) begin
			trap = 1'b0;
			rdv = rda != 0;
			opnd = f3[2] ? {59'd0, src} : src_v;
			case (f3[1:0])
				2'b10: nv = old | opnd;
				2'b11: nv = old & ~opnd;
				default: nv = opnd;
			endcase
			if (f3[1:0] == 2'b01 || src != 0) begin
				case (addr)
					`CSR_MSTATUS: begin
						m_mie = nv[3];
						m_mpie = nv[7];
					end
					`CSR_MTVEC:    m_mtvec = (nv[1:0] > 2'd1) ? {nv[63:2], 2'b00} : nv;
					`CSR_MEPC:     m_mepc = {nv[63:2], 2'b00};
					`CSR_MCAUSE:   m_mcause = nv;
					`CSR_MSCRATCH: m_mscratch = nv;
					default: begin
						mc_base = nv; // mcycle
						mc_t = t + 1;
					end
				endcase
			end
		end
		if (trap) begin
			rev = 1'b1;
			rep = {m_mtvec[63:2], 2'b00};
			if (intr && m_mtvec[1:0] == 2'b01) rep = rep + 64'(cause) * 4;
			m_mepc = {pc_v[63:2], 2'b00};
			m_mcause = {intr, 59'd0, cause};
			m_mpie = m_mie;
			m_mie = 1'b0;
		end
	endfunction

	task automatic check_rd(input csr_pkg::instr_kind_t kind, input logic [4:0] addr_exp,
		input logic [`XLEN-1:0] data_exp);
		if (rd_addr !== addr_exp) begin
			errors++;
			$display("error rd_addr (%s) expected %h got %h", kind.name(), addr_exp, rd_addr);
		end
		if (rd_data !== data_exp) begin
			errors++;
			$display("error rd_data (%s) expected %h got %h", kind.name(), data_exp, rd_data);
		end
	endtask

	task automatic check_redirect(input csr_pkg::trap_cause_t cause,
		input logic [`XLEN-1:0] pc_exp);
		if (redirect_pc !== pc_exp) begin
			errors++;
			$display("error redirect_pc (cause %h) expected %h got %h", cause, pc_exp, redirect_pc);
		end
	endtask

	// compare process samples away from the rising edge
	always @(negedge clk) begin
		if (!reset && due_q.size() != 0 && due_q[0] == cyc) begin
			checks++;
			if (rd_valid !== rdv_q[0]) begin
				errors++;
				$display("error rd_valid (%s) expected %h got %h",
					kind_q[0].name(), rdv_q[0], rd_valid);
			end else if (rdv_q[0]) begin
				check_rd(kind_q[0], rda_q[0], rdd_q[0]);
			end
			if (redirect_valid !== rev_q[0]) begin
				errors++;
				$display("error redirect_valid (%s) expected %h got %h",
					kind_q[0].name(), rev_q[0], redirect_valid);
			end else if (rev_q[0]) begin
				check_redirect(cause_q[0], rep_q[0]);
			end
			void'(due_q.pop_front());
			void'(rdv_q.pop_front());
			void'(rda_q.pop_front());
			void'(rdd_q.pop_front());
			void'(rev_q.pop_front());
			void'(rep_q.pop_front());
			void'(kind_q.pop_front());
			void'(cause_q.pop_front());
		end else if (!reset && (rd_valid || redirect_valid)) begin
			errors++;
			$display("an output was valid with no instruction due at cycle %0d", cyc);
		end
	end

	task automatic issue(input logic [31:0] ins, input logic [`XLEN-1:0] src,
		input logic irq);
		logic                 rdv;
		logic                 rev;
		logic [4:0]           rda;
		logic [`XLEN-1:0]     rdd;
		logic [`XLEN-1:0]     rep;
		csr_pkg::instr_kind_t kind;
		csr_pkg::trap_cause_t cause;
		@(negedge clk);
		instr_valid = 1'b1;
		instr = ins;
		rs1_data = src;
		ext_irq = irq;
		pc = next_pc;
		ref_exec(ins, next_pc, src, irq, cyc + 1, rdv, rda, rdd, rev, rep, kind, cause);
		due_q.push_back(cyc + 2); // two edges through the unit
		rdv_q.push_back(rdv);
		rda_q.push_back(rda);
		rdd_q.push_back(rdd);
		rev_q.push_back(rev);
		rep_q.push_back(rep);
		kind_q.push_back(kind);
		cause_q.push_back(cause);
		next_pc = next_pc + 4;
		issued++;
	endtask

	task automatic idle();
		@(negedge clk);
		instr_valid = 1'b0;
		ext_irq = 1'b0;
	endtask

	task automatic finish_test(input string name);
		idle();
		while (due_q.size() != 0) @(negedge clk);
		tests++;
		$display("test %s done, %0d errors", name, errors - test_err0);
		test_err0 = errors;
	endtask

	task automatic random_ops();
		logic [31:0] r;
		logic [2:0]  f3;
		logic [11:0] a;
		for (int i = 0; i < RAND_N; i++) begin
			r = next_rand();
			case (r[1:0])
				2'd0: a = `CSR_MSCRATCH;
				2'd1: a = `CSR_MEPC;
				2'd2: a = `CSR_MTVEC;
				default: a = `CSR_MSTATUS;
			endcase
			f3 = r[4:2];
			if (f3 == 3'd0) f3 = 3'd1;
			if (f3 == 3'd4) f3 = 3'd5;
			issue(csr_ins(f3, r[9:5], r[14:10], a), {next_rand(), next_rand()}, 1'b0);
		end
		issue(csr_ins(3'b010, 5'd7, 5'd0, `CSR_MSCRATCH), '0, 1'b0); // plain readbacks
		issue(csr_ins(3'b010, 5'd7, 5'd0, `CSR_MEPC), '0, 1'b0);
		issue(csr_ins(3'b010, 5'd7, 5'd0, `CSR_MTVEC), '0, 1'b0);
		issue(csr_ins(3'b010, 5'd7, 5'd0, `CSR_MSTATUS), '0, 1'b0);
	endtask

	initial begin
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		rs1_data = '0;
		ext_irq = 1'b0;
		m_mie = 1'b0;
		m_mpie = 1'b0;
		m_mtvec = '0;
		m_mepc = '0;
		m_mcause = '0;
		m_mscratch = '0;
		mc_base = '0;
		mc_t = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		issued = 0;
		test_err0 = 0;
		lcg_state = 32'hffc6;
		next_pc = 64'h1000;
		@(negedge clk);
		while (reset) @(negedge clk);

		random_ops();
		finish_test("random csr access");

		issue(csr_ins(3'b001, 5'd1, 5'd2, `CSR_MSCRATCH), 64'h5a5a_0000_ffff_1234, 1'b0);
		issue(csr_ins(3'b010, 5'd3, 5'd0, `CSR_MSCRATCH), 64'hffff_ffff_ffff_ffff, 1'b0);
		issue(csr_ins(3'b111, 5'd4, 5'd0, `CSR_MCYCLE), '0, 1'b0); // a write would stall mcycle
		issue(csr_ins(3'b001, 5'd0, 5'd5, `CSR_MSCRATCH), 64'h77, 1'b0); // rd x0
		issue(csr_ins(3'b010, 5'd6, 5'd0, `CSR_MSCRATCH), '0, 1'b0);
		issue(csr_ins(3'b010, 5'd4, 5'd0, `CSR_MCYCLE), '0, 1'b0);
		finish_test("zero source and rd x0");

		issue(csr_ins(3'b001, 5'd0, 5'd1, `CSR_MTVEC), 64'h8000_0100, 1'b0);
		issue(csr_ins(3'b101, 5'd0, 5'd8, `CSR_MSTATUS), '0, 1'b0); // MIE on
		next_pc = 64'h2002;
		issue(32'h0000_0073, '0, 1'b0); // ecall
		issue(csr_ins(3'b010, 5'd1, 5'd0, `CSR_MEPC), '0, 1'b0);
		issue(csr_ins(3'b010, 5'd1, 5'd0, `CSR_MCAUSE), '0, 1'b0);
		issue(csr_ins(3'b010, 5'd1, 5'd0, `CSR_MSTATUS), '0, 1'b0);
		issue(32'h0010_0073, '0, 1'b0); // ebreak
		issue(csr_ins(3'b010, 5'd1, 5'd0, `CSR_MCAUSE), '0, 1'b0);
		issue(csr_ins(3'b010, 5'd2, 5'd0, 12'h7c0), '0, 1'b0); // no such csr
		issue(csr_ins(3'b010, 5'd1, 5'd0, `CSR_MCAUSE), '0, 1'b0);
		finish_test("exceptions");

		issue(csr_ins(3'b001, 5'd0, 5'd1, `CSR_MSTATUS), 64'h80, 1'b0); // MPIE only
		issue(csr_ins(3'b001, 5'd0, 5'd1, `CSR_MEPC), 64'h3004, 1'b0);
		issue(32'h3020_0073, '0, 1'b0); // mret
		issue(csr_ins(3'b010, 5'd1, 5'd0, `CSR_MSTATUS), '0, 1'b0);
		finish_test("mret");

		issue(csr_ins(3'b001, 5'd0, 5'd1, `CSR_MTVEC), 64'h4001, 1'b0); // vectored
		issue(csr_ins(3'b101, 5'd0, 5'd8, `CSR_MSTATUS), '0, 1'b0);
		issue(csr_ins(3'b001, 5'd1, 5'd1, `CSR_MSCRATCH), 64'hdead, 1'b1); // dropped
		issue(csr_ins(3'b010, 5'd1, 5'd0, `CSR_MSCRATCH), '0, 1'b0);
		issue(csr_ins(3'b001, 5'd1, 5'd1, `CSR_MSCRATCH), 64'hbeef, 1'b1); // MIE now clear
		issue(csr_ins(3'b010, 5'd1, 5'd0, `CSR_MCAUSE), '0, 1'b0);
		issue(csr_ins(3'b010, 5'd1, 5'd0, `CSR_MSCRATCH), '0, 1'b0);
		finish_test("external interrupt");

		issue(csr_ins(3'b001, 5'd0, 5'd1, `CSR_MSCRATCH), 64'h1234_5678, 1'b0);
		issue(csr_ins(3'b010, 5'd1, 5'd0, `CSR_MSCRATCH), '0, 1'b0);
		issue(csr_ins(3'b001, 5'd0, 5'd1, `CSR_MCYCLE), 64'h100, 1'b0);
		repeat (4) idle(); // read lands 5 cycles after the write
		issue(csr_ins(3'b010, 5'd1, 5'd0, `CSR_MCYCLE), '0, 1'b0);
		finish_test("back to back and mcycle");

		$display("%0d tests, %0d instructions, %0d checks, %0d errors",
			tests, issued, checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#(WATCHDOG);
		$display("watchdog expired before the tests completed");
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
csr_pkg.sv
csr_decode.sv
csr_file.sv
csr_writeback.sv
csr_unit.sv
csr_clock_gen.sv
csr_unit_assert.sv
csr_unit_tb.sv

/* Makefile */
# Verilator build and run of the CSR unit testbench

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sim.f \
		--top-module csr_unit_tb -o csr_unit_sim
	@out=$$(./obj_dir/csr_unit_sim); echo "$$out"; \
		echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf obj_dir

.PHONY: help test clean
